/* falafel.f */
src/falafel_pkg.sv
src/heap_store.sv
src/heap_arbiter.sv
src/alloc_engine.sv
src/free_engine.sv
src/falafel_top.sv
tests/tb_clk_gen.sv
tests/falafel_chk.sv
tests/falafel_tb.sv

/* run.sh */
#!/bin/sh
# compile the falafel testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module falafel_tb -f falafel.f -o Vfalafel_tb
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

out=$(./obj_dir/Vfalafel_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "STATUS: PASS"; then
  exit 0
fi
exit 1

/* src/alloc_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module alloc_engine #(
  parameter int unsigned HEAP_WORDS = 256
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   alloc_fifo_empty_i,
  output logic                   alloc_fifo_read_o,
  input  falafel_pkg::word_t     alloc_fifo_dout_i,
  input  logic                   resp_fifo_full_i,
  output logic                   resp_fifo_write_o,
  output falafel_pkg::word_t     resp_fifo_din_o,
  output logic                   own_req_o,
  input  logic                   own_gnt_i,
  output logic                   req_val_o,
  input  logic                   req_rdy_i,
  output falafel_pkg::heap_req_t req_o,
  input  logic                   rsp_val_i,
  output logic                   rsp_rdy_o,
  input  falafel_pkg::heap_rsp_t rsp_i
);
  import falafel_pkg::*;

  localparam word_t INIT_BLOCK_SIZE =
    word_t'(HEAP_WORDS) * WORD_SIZE - HEAP_BASE - BLOCK_HEADER_SIZE;

  typedef enum logic [3:0] {
    ST_INIT_HEAD,
    ST_INIT_BLOCK,
    ST_IDLE,
    ST_CHECK_SIZE,
    ST_LOAD_HEAD,
    ST_LOAD_BLOCK,
    ST_PROCESS,
    ST_UPDATE_SIZE,
    ST_STORE_NEW,
    ST_RELINK,
    ST_WRITE_RESP
  } state_e;

  state_e      state_q, state_d;
  logic        wait_q;       // request sent, response pending
  word_t       size_q, size_d;
  word_t       result_q, result_d;
  word_t       cur_q, cur_d;
  word_t       prev_link_q, prev_link_d;  // word that points at cur
  free_block_t buf_q, buf_d;
  logic        mem_op;
  logic        accept;
  logic        done;
  logic        split;
  word_t       split_addr;

  assign mem_op = state_q inside {ST_INIT_HEAD, ST_INIT_BLOCK, ST_LOAD_HEAD, ST_LOAD_BLOCK,
                                  ST_UPDATE_SIZE, ST_STORE_NEW, ST_RELINK};
  assign req_val_o = mem_op && !wait_q && own_gnt_i;
  assign rsp_rdy_o = wait_q;
  assign accept    = req_val_o && req_rdy_i;
  assign done      = rsp_val_i && rsp_rdy_o;
  assign own_req_o = (state_q != ST_IDLE);

  assign resp_fifo_din_o = result_q;

  assign split      = (buf_q.size - size_q) >= MIN_ALLOC_SIZE;
  assign split_addr = cur_q + BLOCK_HEADER_SIZE + size_q;

  always_comb begin
    state_d     = state_q;
    size_d      = size_q;
    result_d    = result_q;
    cur_d       = cur_q;
    prev_link_d = prev_link_q;
    buf_d       = buf_q;
    req_o       = '0;
    alloc_fifo_read_o = 1'b0;
    resp_fifo_write_o = 1'b0;

    unique case (state_q)
      ST_INIT_HEAD: begin
        req_o.op   = LSU_OP_STORE_WORD;
        req_o.addr = FREE_LIST_PTR;
        req_o.word = HEAP_BASE;
        if (done) begin
          state_d = ST_INIT_BLOCK;
        end
      end

      ST_INIT_BLOCK: begin  // one block over the whole heap
        req_o.op    = LSU_OP_STORE_BLOCK;
        req_o.addr  = HEAP_BASE;
        req_o.block = '{size: INIT_BLOCK_SIZE, next_ptr: NULL_PTR};
        if (done) begin
          state_d = ST_IDLE;
        end
      end

      ST_IDLE: begin
        if (!alloc_fifo_empty_i) begin
          alloc_fifo_read_o = 1'b1;
          size_d  = alloc_fifo_dout_i;
          state_d = ST_CHECK_SIZE;
        end
      end

      ST_CHECK_SIZE: begin
        if (size_q == '0) begin
          result_d = NULL_PTR;
          state_d  = ST_WRITE_RESP;
        end else begin
          size_d  = align_size(size_q);
          state_d = ST_LOAD_HEAD;
        end
      end

      ST_LOAD_HEAD: begin
        req_o.op   = LSU_OP_LOAD_WORD;
        req_o.addr = FREE_LIST_PTR;
        if (done) begin
          // head seen as a zero-size block whose next_ptr word is the head word
          buf_d   = '{size: '0, next_ptr: rsp_i.word};
          cur_d   = FREE_LIST_PTR - BLOCK_NEXT_PTR_OFFSET;
          state_d = ST_PROCESS;
        end
      end

      ST_LOAD_BLOCK: begin
        req_o.op   = LSU_OP_LOAD_BLOCK;
        req_o.addr = buf_q.next_ptr;
        if (accept) begin
          prev_link_d = cur_q + BLOCK_NEXT_PTR_OFFSET;
          cur_d       = buf_q.next_ptr;
        end
        if (done) begin
          buf_d   = rsp_i.block;
          state_d = ST_PROCESS;
        end
      end

      ST_PROCESS: begin
        if (buf_q.size >= size_q) begin
          result_d = cur_q + WORD_SIZE;
          state_d  = split ? ST_UPDATE_SIZE : ST_RELINK;
        end else if (buf_q.next_ptr == NULL_PTR) begin
          result_d = ERR_NOMEM;
          state_d  = ST_WRITE_RESP;
        end else begin
          state_d = ST_LOAD_BLOCK;
        end
      end

      ST_UPDATE_SIZE: begin
        req_o.op   = LSU_OP_STORE_WORD;
        req_o.addr = cur_q;
        req_o.word = size_q;
        if (done) begin
          state_d = ST_STORE_NEW;
        end
      end

      ST_STORE_NEW: begin  // leftover becomes a free block
        req_o.op    = LSU_OP_STORE_BLOCK;
        req_o.addr  = split_addr;
        req_o.block = '{size: buf_q.size - size_q - BLOCK_HEADER_SIZE,
                        next_ptr: buf_q.next_ptr};
        if (done) begin
          state_d = ST_RELINK;
        end
      end

      ST_RELINK: begin
        req_o.op   = LSU_OP_STORE_WORD;
        req_o.addr = prev_link_q;
        req_o.word = split ? split_addr : buf_q.next_ptr;
        if (done) begin
          state_d = ST_WRITE_RESP;
        end
      end

      ST_WRITE_RESP: begin  // ownership kept until the write goes out
        if (!resp_fifo_full_i) begin
          resp_fifo_write_o = 1'b1;
          state_d = ST_IDLE;
        end
      end

      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= ST_INIT_HEAD;
      wait_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      wait_q  <= accept || (wait_q && !done);
    end
  end

  always_ff @(posedge clk_i) begin
    size_q      <= size_d;
    result_q    <= result_d;
    cur_q       <= cur_d;
    prev_link_q <= prev_link_d;
    buf_q       <= buf_d;
  end

endmodule

`default_nettype wire

/* src/falafel_pkg.sv */
`default_nettype none

package falafel_pkg;

  localparam int DATA_W = 32;

  typedef logic [DATA_W-1:0] word_t;

  localparam word_t WORD_SIZE             = 32'd4;
  localparam word_t BLOCK_HEADER_SIZE     = 32'd8;   // size word + next_ptr word
  localparam word_t BLOCK_NEXT_PTR_OFFSET = 32'd4;
  localparam word_t BLOCK_ALIGNMENT       = 32'd8;
  localparam word_t MIN_ALLOC_SIZE        = 32'd16;
  localparam word_t NULL_PTR              = 32'd0;
  localparam word_t ERR_NOMEM             = '1;
  localparam word_t FREE_LIST_PTR         = 32'd4;   // list head word
  localparam word_t HEAP_BASE             = 32'd8;

  typedef struct packed {
    word_t size;
    word_t next_ptr;
  } free_block_t;

  typedef enum logic [1:0] {
    LSU_OP_LOAD_WORD,
    LSU_OP_STORE_WORD,
    LSU_OP_LOAD_BLOCK,
    LSU_OP_STORE_BLOCK
  } lsu_op_e;

  typedef struct packed {
    lsu_op_e     op;
    word_t       addr;
    word_t       word;   // store data of word ops
    free_block_t block;  // store data of block ops
  } heap_req_t;

  typedef struct packed {
    word_t       word;
    free_block_t block;
  } heap_rsp_t;

  // round up to the next multiple of BLOCK_ALIGNMENT
  function automatic word_t align_size(word_t size);
    return (size + BLOCK_ALIGNMENT - 32'd1) & ~(BLOCK_ALIGNMENT - 32'd1);
  endfunction

endpackage

`default_nettype wire

/* src/falafel_top.sv */
`timescale 1ns/1ps
`default_nettype none

module falafel_top #(
  parameter int unsigned HEAP_WORDS = 256
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               alloc_fifo_empty_i,
  output logic               alloc_fifo_read_o,
  input  falafel_pkg::word_t alloc_fifo_dout_i,
  input  logic               free_fifo_empty_i,
  output logic               free_fifo_read_o,
  input  falafel_pkg::word_t free_fifo_dout_i,
  input  logic               resp_fifo_full_i,
  output logic               resp_fifo_write_o,
  output falafel_pkg::word_t resp_fifo_din_o
);
  import falafel_pkg::*;

  logic      alloc_own_req, alloc_own_gnt, alloc_req_val, alloc_req_rdy;
  logic      alloc_rsp_val, alloc_rsp_rdy;
  heap_req_t alloc_req;
  heap_rsp_t alloc_rsp;

  logic      free_own_req, free_own_gnt, free_req_val, free_req_rdy;
  logic      free_rsp_val, free_rsp_rdy;
  heap_req_t free_req;
  heap_rsp_t free_rsp;

  logic      st_req_val, st_req_rdy, st_rsp_val, st_rsp_rdy;
  heap_req_t st_req;
  heap_rsp_t st_rsp;

  alloc_engine #(
    .HEAP_WORDS(HEAP_WORDS)
  ) u_alloc (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .alloc_fifo_empty_i (alloc_fifo_empty_i),
    .alloc_fifo_read_o  (alloc_fifo_read_o),
    .alloc_fifo_dout_i  (alloc_fifo_dout_i),
    .resp_fifo_full_i   (resp_fifo_full_i),
    .resp_fifo_write_o  (resp_fifo_write_o),
    .resp_fifo_din_o    (resp_fifo_din_o),
    .own_req_o          (alloc_own_req),
    .own_gnt_i          (alloc_own_gnt),
    .req_val_o          (alloc_req_val),
    .req_rdy_i          (alloc_req_rdy),
    .req_o              (alloc_req),
    .rsp_val_i          (alloc_rsp_val),
    .rsp_rdy_o          (alloc_rsp_rdy),
    .rsp_i              (alloc_rsp)
  );

  free_engine u_free (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .free_fifo_empty_i (free_fifo_empty_i),
    .free_fifo_read_o  (free_fifo_read_o),
    .free_fifo_dout_i  (free_fifo_dout_i),
    .own_req_o         (free_own_req),
    .own_gnt_i         (free_own_gnt),
    .req_val_o         (free_req_val),
    .req_rdy_i         (free_req_rdy),
    .req_o             (free_req),
    .rsp_val_i         (free_rsp_val),
    .rsp_rdy_o         (free_rsp_rdy),
    .rsp_i             (free_rsp)
  );

  heap_arbiter u_arb (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .alloc_own_req_i (alloc_own_req),
    .alloc_own_gnt_o (alloc_own_gnt),
    .alloc_req_val_i (alloc_req_val),
    .alloc_req_rdy_o (alloc_req_rdy),
    .alloc_req_i     (alloc_req),
    .alloc_rsp_val_o (alloc_rsp_val),
    .alloc_rsp_rdy_i (alloc_rsp_rdy),
    .alloc_rsp_o     (alloc_rsp),
    .free_own_req_i  (free_own_req),
    .free_own_gnt_o  (free_own_gnt),
    .free_req_val_i  (free_req_val),
    .free_req_rdy_o  (free_req_rdy),
    .free_req_i      (free_req),
    .free_rsp_val_o  (free_rsp_val),
    .free_rsp_rdy_i  (free_rsp_rdy),
    .free_rsp_o      (free_rsp),
    .st_req_val_o    (st_req_val),
    .st_req_rdy_i    (st_req_rdy),
    .st_req_o        (st_req),
    .st_rsp_val_i    (st_rsp_val),
    .st_rsp_rdy_o    (st_rsp_rdy),
    .st_rsp_i        (st_rsp)
  );

  heap_store #(
    .HEAP_WORDS(HEAP_WORDS)
  ) u_store (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_val_i (st_req_val),
    .req_rdy_o (st_req_rdy),
    .req_i     (st_req),
    .rsp_val_o (st_rsp_val),
    .rsp_rdy_i (st_rsp_rdy),
    .rsp_o     (st_rsp)
  );

endmodule

`default_nettype wire

/* src/free_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module free_engine (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   free_fifo_empty_i,
  output logic                   free_fifo_read_o,
  input  falafel_pkg::word_t     free_fifo_dout_i,
  output logic                   own_req_o,
  input  logic                   own_gnt_i,
  output logic                   req_val_o,
  input  logic                   req_rdy_i,
  output falafel_pkg::heap_req_t req_o,
  input  logic                   rsp_val_i,
  output logic                   rsp_rdy_o,
  input  falafel_pkg::heap_rsp_t rsp_i
);
  import falafel_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOAD_HEAD,
    ST_LOAD_BLOCK,
    ST_PROCESS,
    ST_STORE_NEXT,
    ST_RELINK,
    ST_DONE
  } state_e;

  state_e state_q, state_d;
  logic   wait_q;
  word_t  blk_q, blk_d;    // block being freed
  word_t  cur_q, cur_d;
  word_t  next_q, next_d;  // next_ptr of cur
  logic   mem_op;
  logic   accept;
  logic   done;

  assign mem_op    = state_q inside {ST_LOAD_HEAD, ST_LOAD_BLOCK, ST_STORE_NEXT, ST_RELINK};
  assign req_val_o = mem_op && !wait_q && own_gnt_i;
  assign rsp_rdy_o = wait_q;
  assign accept    = req_val_o && req_rdy_i;
  assign done      = rsp_val_i && rsp_rdy_o;
  assign own_req_o = !(state_q inside {ST_IDLE, ST_DONE});

  always_comb begin
    state_d = state_q;
    blk_d   = blk_q;
    cur_d   = cur_q;
    next_d  = next_q;
    req_o   = '0;
    free_fifo_read_o = 1'b0;

    unique case (state_q)
      ST_IDLE: begin
        if (!free_fifo_empty_i) begin
          free_fifo_read_o = 1'b1;
          // pointer sits one word into an aligned block
          blk_d   = align_size(free_fifo_dout_i) - BLOCK_HEADER_SIZE;
          state_d = ST_LOAD_HEAD;
        end
      end

      ST_LOAD_HEAD: begin
        req_o.op   = LSU_OP_LOAD_WORD;
        req_o.addr = FREE_LIST_PTR;
        if (done) begin
          next_d  = rsp_i.word;
          cur_d   = FREE_LIST_PTR - BLOCK_NEXT_PTR_OFFSET;  // head as pseudo block
          state_d = ST_PROCESS;
        end
      end

      ST_LOAD_BLOCK: begin
        req_o.op   = LSU_OP_LOAD_BLOCK;
        req_o.addr = next_q;
        if (accept) begin
          cur_d = next_q;
        end
        if (done) begin
          next_d  = rsp_i.block.next_ptr;
          state_d = ST_PROCESS;
        end
      end

      ST_PROCESS: begin
        if (next_q == NULL_PTR || next_q > blk_q) begin
          state_d = ST_STORE_NEXT;
        end else begin
          state_d = ST_LOAD_BLOCK;
        end
      end

      ST_STORE_NEXT: begin
        req_o.op   = LSU_OP_STORE_WORD;
        req_o.addr = blk_q + BLOCK_NEXT_PTR_OFFSET;
        req_o.word = next_q;
        if (done) begin
          state_d = ST_RELINK;
        end
      end

      ST_RELINK: begin
        req_o.op   = LSU_OP_STORE_WORD;
        req_o.addr = cur_q + BLOCK_NEXT_PTR_OFFSET;
        req_o.word = blk_q;
        if (done) begin
          state_d = ST_DONE;
        end
      end

      ST_DONE: state_d = ST_IDLE;  // own_req low, lets the grant drop

      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      wait_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      wait_q  <= accept || (wait_q && !done);
    end
  end

  always_ff @(posedge clk_i) begin
    blk_q  <= blk_d;
    cur_q  <= cur_d;
    next_q <= next_d;
  end

endmodule

`default_nettype wire

/* src/heap_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module heap_arbiter (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  input  logic                   alloc_own_req_i,
  output logic                   alloc_own_gnt_o,
  input  logic                   alloc_req_val_i,
  output logic                   alloc_req_rdy_o,
  input  falafel_pkg::heap_req_t alloc_req_i,
  output logic                   alloc_rsp_val_o,
  input  logic                   alloc_rsp_rdy_i,
  output falafel_pkg::heap_rsp_t alloc_rsp_o,

  input  logic                   free_own_req_i,
  output logic                   free_own_gnt_o,
  input  logic                   free_req_val_i,
  output logic                   free_req_rdy_o,
  input  falafel_pkg::heap_req_t free_req_i,
  output logic                   free_rsp_val_o,
  input  logic                   free_rsp_rdy_i,
  output falafel_pkg::heap_rsp_t free_rsp_o,

  output logic                   st_req_val_o,
  input  logic                   st_req_rdy_i,
  output falafel_pkg::heap_req_t st_req_o,
  input  logic                   st_rsp_val_i,
  output logic                   st_rsp_rdy_o,
  input  falafel_pkg::heap_rsp_t st_rsp_i
);

  typedef enum logic [1:0] {
    OWN_NONE,
    OWN_ALLOC,
    OWN_FREE
  } owner_e;

  owner_e owner_q;

  // ownership lasts the whole operation, alloc wins ties
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      owner_q <= OWN_NONE;
    end else begin
      unique case (owner_q)
        OWN_NONE: begin
          if (alloc_own_req_i) begin
            owner_q <= OWN_ALLOC;
          end else if (free_own_req_i) begin
            owner_q <= OWN_FREE;
          end
        end
        OWN_ALLOC: begin
          if (!alloc_own_req_i) begin
            owner_q <= OWN_NONE;
          end
        end
        OWN_FREE: begin
          if (!free_own_req_i) begin
            owner_q <= OWN_NONE;
          end
        end
        default: owner_q <= OWN_NONE;
      endcase
    end
  end

  assign alloc_own_gnt_o = (owner_q == OWN_ALLOC);
  assign free_own_gnt_o  = (owner_q == OWN_FREE);

  assign st_req_val_o    = (alloc_own_gnt_o && alloc_req_val_i) ||
                           (free_own_gnt_o && free_req_val_i);
  assign st_req_o        = free_own_gnt_o ? free_req_i : alloc_req_i;
  assign alloc_req_rdy_o = alloc_own_gnt_o && st_req_rdy_i;
  assign free_req_rdy_o  = free_own_gnt_o && st_req_rdy_i;

  assign alloc_rsp_val_o = alloc_own_gnt_o && st_rsp_val_i;
  assign free_rsp_val_o  = free_own_gnt_o && st_rsp_val_i;
  assign alloc_rsp_o     = st_rsp_i;  // only the owner sees a valid
  assign free_rsp_o      = st_rsp_i;
  assign st_rsp_rdy_o    = (alloc_own_gnt_o && alloc_rsp_rdy_i) ||
                           (free_own_gnt_o && free_rsp_rdy_i);

endmodule

`default_nettype wire

/* src/heap_store.sv */
`timescale 1ns/1ps
`default_nettype none

module heap_store #(
  parameter int unsigned HEAP_WORDS = 256
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   req_val_i,
  output logic                   req_rdy_o,
  input  falafel_pkg::heap_req_t req_i,
  output logic                   rsp_val_o,
  input  logic                   rsp_rdy_i,
  output falafel_pkg::heap_rsp_t rsp_o
);
  import falafel_pkg::*;

  localparam int unsigned IDX_W = $clog2(HEAP_WORDS);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BLK_NEXT,  // second word of a block op
    ST_RSP
  } state_e;

  state_e           state_q;
  heap_req_t        req_q;
  heap_rsp_t        rsp_q;
  word_t            mem_q [HEAP_WORDS];
  logic             accept;
  logic [IDX_W-1:0] idx_first;
  logic [IDX_W-1:0] idx_next;

  assign req_rdy_o = (state_q == ST_IDLE);
  assign accept    = req_val_i && req_rdy_o;
  assign rsp_val_o = (state_q == ST_RSP);
  assign rsp_o     = rsp_q;
  assign idx_first = IDX_W'(req_i.addr / WORD_SIZE);
  assign idx_next  = IDX_W'(req_q.addr / WORD_SIZE + 32'd1);

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
    end else begin
      unique case (state_q)
        ST_IDLE: begin
          if (accept) begin
            state_q <= (req_i.op inside {LSU_OP_LOAD_BLOCK, LSU_OP_STORE_BLOCK}) ?
                       ST_BLK_NEXT : ST_RSP;
          end
        end
        ST_BLK_NEXT: state_q <= ST_RSP;
        ST_RSP: begin
          if (rsp_rdy_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= req_i;
      unique case (req_i.op)
        LSU_OP_LOAD_WORD:  rsp_q.word <= mem_q[idx_first];
        LSU_OP_STORE_WORD: mem_q[idx_first] <= req_i.word;
        LSU_OP_LOAD_BLOCK: rsp_q.block.size <= mem_q[idx_first];
        default:           mem_q[idx_first] <= req_i.block.size;
      endcase
    end
    if (state_q == ST_BLK_NEXT) begin
      if (req_q.op == LSU_OP_LOAD_BLOCK) begin
        rsp_q.block.next_ptr <= mem_q[idx_next];
      end else begin
        mem_q[idx_next] <= req_q.block.next_ptr;
      end
    end
  end

endmodule

`default_nettype wire

/* tests/falafel_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module falafel_chk (
  input logic clk_i,
  input logic rst_ni,
  input logic alloc_req_i,
  input logic alloc_gnt_i,
  input logic free_req_i,
  input logic free_gnt_i,
  input logic st_req_val_i
);

  grants_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(alloc_gnt_i && free_gnt_i))
    else $error("alloc and free grants high together");

  alloc_gnt_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    alloc_gnt_i && alloc_req_i |=> alloc_gnt_i)
    else $error("alloc grant dropped while still requested");

  free_gnt_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    free_gnt_i && free_req_i |=> free_gnt_i)
    else $error("free grant dropped while still requested");

  // storage traffic only from the owner, while it still asks
  req_under_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(st_req_val_i) |-> (alloc_gnt_i && alloc_req_i) || (free_gnt_i && free_req_i))
    else $error("storage request raised without a held grant");

endmodule

bind heap_arbiter falafel_chk chk0 (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .alloc_req_i  (alloc_own_req_i),
  .alloc_gnt_i  (alloc_own_gnt_o),
  .free_req_i   (free_own_req_i),
  .free_gnt_i   (free_own_gnt_o),
  .st_req_val_i (st_req_val_o)
);

`default_nettype wire

/* tests/falafel_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module falafel_tb;
  import falafel_pkg::*;

  localparam int unsigned HEAP_WORDS = 256;
  localparam int TIMEOUT_CYCLES = 2000;
  localparam int HOLD_CYCLES    = 30;
  localparam int RANDOM_OPS     = 40;

  logic  clk;
  logic  rst_n;
  logic  alloc_empty;
  logic  free_empty;
  logic  resp_full;
  word_t alloc_dout;
  word_t free_dout;
  logic  alloc_read;
  logic  free_read;
  logic  resp_write;
  word_t resp_din;

  word_t alloc_fifo_q[$];
  word_t free_fifo_q[$];
  word_t exp_q[$];        // expected alloc results, in order
  logic  resp_full_req;
  word_t last_rsp = '0;   // most recent value written to the resp fifo

  // reference heap: free list sorted by address, plus the live blocks
  word_t fl_addr[$];
  word_t fl_size[$];
  word_t live_ptr[$];
  word_t live_size[$];
  word_t fresh_ptr[3];

  string test_name = "reset";
  int    tests_run = 0;
  int    checks = 0;
  int    errors = 0;
  int    test_err0 = 0;
  int    alloc_reads = 0;
  int    free_reads = 0;
  int    rsp_count = 0;
  bit    aborted = 1'b0;

  tb_clk_gen clk_gen0 (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  falafel_top #(
    .HEAP_WORDS(HEAP_WORDS)
  ) dut0 (
    .clk_i              (clk),
    .rst_ni             (rst_n),
    .alloc_fifo_empty_i (alloc_empty),
    .alloc_fifo_read_o  (alloc_read),
    .alloc_fifo_dout_i  (alloc_dout),
    .free_fifo_empty_i  (free_empty),
    .free_fifo_read_o   (free_read),
    .free_fifo_dout_i   (free_dout),
    .resp_fifo_full_i   (resp_full),
    .resp_fifo_write_o  (resp_write),
    .resp_fifo_din_o    (resp_din)
  );

  task automatic check_value(input string what, input word_t exp, input word_t act);
    checks++;
    assert (act == exp) else begin
      $display("CHECK FAILED %s (%s): expected %h, actual %h", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout in %s: %s did not happen within %0d cycles",
             test_name, what, TIMEOUT_CYCLES);
    errors++;
    aborted = 1'b1;
  endtask

  // first-fit over the sorted model, split when the leftover is big enough
  function automatic word_t ref_alloc(word_t size);
    word_t need;
    word_t left;
    word_t blk;
    word_t result;
    bit    found;
    int    i;
    result = ERR_NOMEM;
    found  = 1'b0;
    if (size == 32'd0) begin
      result = NULL_PTR;
      found  = 1'b1;
    end
    need = ((size + BLOCK_ALIGNMENT - 32'd1) / BLOCK_ALIGNMENT) * BLOCK_ALIGNMENT;
    for (i = 0; i < fl_addr.size() && !found; i++) begin
      if (fl_size[i] >= need) begin
        found = 1'b1;
        blk   = fl_addr[i];
        left  = fl_size[i] - need;
        if (left >= MIN_ALLOC_SIZE) begin
          fl_addr[i] = blk + BLOCK_HEADER_SIZE + need;
          fl_size[i] = left - BLOCK_HEADER_SIZE;
          live_size.push_back(need);
        end else begin
          live_size.push_back(fl_size[i]);  // whole block, keeps its size
          fl_addr.delete(i);
          fl_size.delete(i);
        end
        live_ptr.push_back(blk + WORD_SIZE);
        result = blk + WORD_SIZE;
      end
    end
    return result;
  endfunction

  function automatic void model_free(word_t ptr);
    word_t size;
    int    i;
    int    pos;
    bit    found;
    size  = 32'd0;
    found = 1'b0;
    for (i = 0; i < live_ptr.size() && !found; i++) begin
      if (live_ptr[i] == ptr) begin
        found = 1'b1;
        size  = live_size[i];
        live_ptr.delete(i);
        live_size.delete(i);
      end
    end
    pos = 0;
    while (pos < fl_addr.size() && fl_addr[pos] < ptr - WORD_SIZE) begin
      pos++;
    end
    fl_addr.insert(pos, ptr - WORD_SIZE);
    fl_size.insert(pos, size);
  endfunction

  task automatic wait_responses(input int target, input string what);
    int n;
    n = 0;
    while (rsp_count < target && n < TIMEOUT_CYCLES) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (rsp_count < target) begin
      report_timeout(what);
    end
  endtask

  task automatic wait_reads(input bit from_free, input int target, input string what);
    int n;
    n = 0;
    while ((from_free ? free_reads : alloc_reads) < target && n < TIMEOUT_CYCLES) begin
      @(posedge clk);
      #1;
      n++;
    end
    if ((from_free ? free_reads : alloc_reads) < target) begin
      report_timeout(what);
    end
  endtask

  task automatic send_alloc(input word_t size, output word_t exp);
    exp = ref_alloc(size);
    exp_q.push_back(exp);
    alloc_fifo_q.push_back(size);
  endtask

  task automatic do_alloc(input word_t size, output word_t exp);
    int target;
    @(posedge clk);
    #1;
    target = rsp_count + 1;
    send_alloc(size, exp);
    wait_responses(target, "alloc response");
  endtask

  // a free has no response, its fifo read is the only visible sign
  task automatic do_free(input word_t ptr);
    int target;
    @(posedge clk);
    #1;
    target = free_reads + 1;
    model_free(ptr);
    free_fifo_q.push_back(ptr);
    wait_reads(1'b1, target, "free fifo read");
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_err0 = errors;
    tests_run++;
  endtask

  task automatic end_test();
    $display("test %s %s", test_name, (errors == test_err0) ? "ok" : "FAILED");
  endtask

  task automatic run_zero_size();
    word_t p;
    begin_test("zero_size");
    do_alloc(32'd0, p);
    if (aborted) return;
    check_value("zero size result", NULL_PTR, last_rsp);
    end_test();
  endtask

  task automatic run_fresh_heap();
    begin_test("fresh_heap");
    do_alloc(32'd5, fresh_ptr[0]);
    if (aborted) return;
    do_alloc(32'd24, fresh_ptr[1]);
    if (aborted) return;
    do_alloc(32'd9, fresh_ptr[2]);
    if (aborted) return;
    end_test();
  endtask

  task automatic run_reuse();
    word_t p;
    begin_test("reuse");
    do_free(fresh_ptr[1]);
    if (aborted) return;
    do_alloc(32'd16, p);
    if (aborted) return;
    check_value("reused pointer", fresh_ptr[1], last_rsp);
    do_alloc(32'd8, p);
    if (aborted) return;
    end_test();
  endtask

  task automatic run_exhaustion();
    word_t snap_addr[$];
    word_t snap_size[$];
    word_t p;
    word_t addr;
    int    n;
    begin_test("exhaustion");
    snap_addr = fl_addr;
    snap_size = fl_size;
    do_alloc(32'd2000, p);
    if (aborted) return;
    check_value("nomem result", ERR_NOMEM, last_rsp);
    // walk the list in heap storage, it must still hold the earlier blocks
    addr = dut0.u_store.mem_q[FREE_LIST_PTR / WORD_SIZE];
    n    = 0;
    while (addr != NULL_PTR && n <= snap_addr.size() &&
           addr / WORD_SIZE + 32'd1 < HEAP_WORDS) begin
      if (n < snap_addr.size()) begin
        check_value("free block addr", snap_addr[n], addr);
        check_value("free block size", snap_size[n], dut0.u_store.mem_q[addr / WORD_SIZE]);
      end
      addr = dut0.u_store.mem_q[addr / WORD_SIZE + 32'd1];
      n++;
    end
    check_value("free list length", word_t'(snap_addr.size()), word_t'(n));
    end_test();
  endtask

  task automatic run_backpressure();
    word_t p;
    int    reads0;
    int    rsp0;
    begin_test("backpressure");
    @(posedge clk);
    #1;
    reads0 = alloc_reads;
    rsp0   = rsp_count;
    resp_full_req = 1'b1;
    send_alloc(32'd40, p);
    send_alloc(32'd16, p);  // must stay in the fifo until the first write
    wait_reads(1'b0, reads0 + 1, "alloc fifo read");
    if (aborted) return;
    repeat (HOLD_CYCLES) @(posedge clk);
    #1;
    check_value("writes while full", word_t'(rsp0), word_t'(rsp_count));
    check_value("alloc reads while full", word_t'(reads0 + 1), word_t'(alloc_reads));
    resp_full_req = 1'b0;
    wait_responses(rsp0 + 1, "first write after full");
    if (aborted) return;
    check_value("alloc reads at first write", word_t'(reads0 + 1), word_t'(alloc_reads));
    wait_responses(rsp0 + 2, "second alloc response");
    if (aborted) return;
    end_test();
  endtask

  task automatic run_random_mix();
    word_t p;
    word_t size;
    int    idx;
    int    i;
    begin_test("random_mix");
    for (i = 0; i < RANDOM_OPS; i++) begin
      if (live_ptr.size() == 0 || $urandom_range(0, 1) == 0) begin
        size = word_t'($urandom_range(1, 120));
        do_alloc(size, p);
      end else begin
        idx = int'($urandom_range(0, live_ptr.size() - 1));
        do_free(live_ptr[idx]);
      end
      if (aborted) return;
    end
    end_test();
  endtask

  // fifo models, inputs change 5 ns after the rising edge
  initial begin
    alloc_empty   = 1'b1;
    alloc_dout    = '0;
    free_empty    = 1'b1;
    free_dout     = '0;
    resp_full     = 1'b0;
    resp_full_req = 1'b0;
    forever begin
      @(posedge clk);
      #5;
      alloc_empty = (alloc_fifo_q.size() == 0);
      free_empty  = (free_fifo_q.size() == 0);
      if (alloc_empty) alloc_dout = '0;
      else alloc_dout = alloc_fifo_q[0];
      if (free_empty) free_dout = '0;
      else free_dout = free_fifo_q[0];
      resp_full = resp_full_req;
    end
  end

  // strobes are sampled mid-cycle, the compare happens here
  initial begin
    forever begin
      @(negedge clk);
      if (rst_n) begin
        if (alloc_read) begin
          assert (!alloc_empty) else begin
            $display("alloc fifo read while it was empty in %s", test_name);
            errors++;
          end
          if (alloc_fifo_q.size() > 0) begin
            void'(alloc_fifo_q.pop_front());
            alloc_reads++;
          end
        end
        if (free_read) begin
          assert (!free_empty) else begin
            $display("free fifo read while it was empty in %s", test_name);
            errors++;
          end
          if (free_fifo_q.size() > 0) begin
            void'(free_fifo_q.pop_front());
            free_reads++;
          end
        end
        if (resp_write) begin
          assert (!resp_full) else begin
            $display("response written while the fifo was full in %s", test_name);
            errors++;
          end
          if (exp_q.size() == 0) begin
            $display("response %h arrived with no alloc pending in %s", resp_din, test_name);
            errors++;
          end else begin
            check_value("alloc result", exp_q.pop_front(), resp_din);
          end
          last_rsp = resp_din;
          rsp_count++;
        end
      end
    end
  end

  initial begin
    int n;
    void'($urandom(32'h3161_63cd));
    fl_addr.push_back(HEAP_BASE);
    fl_size.push_back(word_t'(HEAP_WORDS) * WORD_SIZE - HEAP_BASE - BLOCK_HEADER_SIZE);
    n = 0;
    while (rst_n !== 1'b1 && n < 10) begin
      @(posedge clk);
      n++;
    end
    if (rst_n !== 1'b1) begin
      report_timeout("reset release");
    end
    if (!aborted) run_zero_size();
    if (!aborted) run_fresh_heap();
    if (!aborted) run_reuse();
    if (!aborted) run_exhaustion();
    if (!aborted) run_backpressure();
    if (!aborted) run_random_mix();
    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0 && !aborted) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tests/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;  // 40 ns period
  end

  initial begin
    rst_no = 1'b0;
    repeat (2) @(posedge clk_o);
    #5;
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire
